// ==== rvTypes.sv ====
//----------------------------------------
// RISC-V widths shared by the fetch path.
// RV32 only, so addresses are 32 bits.
//----------------------------------------
`default_nettype none

package rvTypes;

    typedef logic [31:0] vaddr_t;    // byte address.
    typedef logic [31:0] word_t;     // one full instruction word.
    typedef logic [15:0] half_t;     // one compressed parcel.
    typedef logic [3:0]  intCode_t;  // mcause code field.

    // machine timer interrupt cause.
    localparam intCode_t TIMER_INT_CODE = 4'd7;

    localparam int HALF_BYTES = 2;   // bytes per parcel.

endpackage

`default_nettype wire

// ==== fetchTypes.sv ====
//----------------------------------------
// sizes of the fetch front end.
// line and memory sizes must stay powers of two.
//----------------------------------------
`default_nettype none

package fetchTypes;

    localparam int LINE_WIDTH     = 128;
    localparam int WORDS_PER_LINE = LINE_WIDTH / $bits(rvTypes::word_t);
    typedef logic [LINE_WIDTH-1:0] line_t;

    localparam int MEM_LINES        = 16;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_WIDTH / 8);  // byte offset inside a line.
    localparam int LINE_INDEX_BITS  = $clog2(MEM_LINES);
    typedef logic [LINE_INDEX_BITS-1:0] lineIndex_t;
    // first address past the memory.
    localparam rvTypes::vaddr_t MEM_BYTES = rvTypes::vaddr_t'(MEM_LINES * LINE_WIDTH / 8);

    localparam int BUFFER_DEPTH = 8;  // halfword entries.
    typedef logic [3:0] bufCount_t;   // holds 0 up to BUFFER_DEPTH.
    typedef logic [$clog2(BUFFER_DEPTH)-1:0] bufPtr_t;

    typedef logic [31:0] timeCount_t;

    typedef enum logic [1:0] {
        Idle,     // waiting for start.
        Run,      // one request per cycle.
        Recover   // bubble after a stall.
    } fetchState_t;

endpackage

`default_nettype wire

// ==== fetchIfs.sv ====
//----------------------------------------
// line read and buffer write buses.
// no handshake, the writer watches writableCount.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

// line returned by the line memory.
interface lineReadIf;
    logic                valid;
    rvTypes::vaddr_t     pc;     // pc that fetched the line.
    fetchTypes::line_t   line;
    logic                fault;  // pc beyond the memory.

    modport source (output valid, pc, line, fault);
    modport sink   (input  valid, pc, line, fault);
endinterface

// two-entry write into the halfword buffer.
interface insnBufferIf;
    logic                   writeLow;
    logic                   writeHigh;
    rvTypes::vaddr_t        pcLow;
    rvTypes::vaddr_t        pcHigh;
    rvTypes::half_t         halfLow;
    rvTypes::half_t         halfHigh;
    logic                   fault;
    logic                   intValid;
    rvTypes::intCode_t      intCode;
    fetchTypes::bufCount_t  writableCount;  // free entries.

    modport writer (output writeLow, writeHigh, pcLow, pcHigh, halfLow, halfHigh,
                    fault, intValid, intCode, input writableCount);
    modport buffer (input writeLow, writeHigh, pcLow, pcHigh, halfLow, halfHigh,
                    fault, intValid, intCode, output writableCount);
endinterface

`default_nettype wire

// ==== fetchController.sv ====
//----------------------------------------
// fetch pc state machine.
// redirect wins over start and stall.
// a stall costs one idle cycle before the retry.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetchController (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            start,
    input  wire rvTypes::vaddr_t startPc,
    input  wire logic            redirect,
    input  wire rvTypes::vaddr_t redirectPc,
    input  wire logic            stall,
    output logic                 reqValid,
    output rvTypes::vaddr_t      reqPc
);

    fetchTypes::fetchState_t state;
    rvTypes::vaddr_t fetchPc;   // address of the next request.
    rvTypes::vaddr_t lastPc;    // address of the request in flight.
    rvTypes::vaddr_t nextPc;

    // drop to the word boundary, then step one word.
    always_comb begin
        nextPc = (fetchPc & ~rvTypes::vaddr_t'(rvTypes::HALF_BYTES))
               + rvTypes::vaddr_t'(2 * rvTypes::HALF_BYTES);
    end

    // a stalled cycle issues nothing, so no line overtakes the retry.
    assign reqValid = (state == fetchTypes::Run) && !stall;
    assign reqPc    = fetchPc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= fetchTypes::Idle;
            fetchPc <= '0;
            lastPc  <= '0;
        end else if (redirect) begin
            state   <= fetchTypes::Run;   // flushes from any state.
            fetchPc <= redirectPc;
        end else begin
            case (state)
                fetchTypes::Idle: begin
                    if (start) begin
                        state   <= fetchTypes::Run;
                        fetchPc <= startPc;
                    end
                end
                fetchTypes::Run: begin
                    if (stall) begin
                        state   <= fetchTypes::Recover;
                        fetchPc <= lastPc;     // rewind to the line that did not fit.
                    end else begin
                        fetchPc <= nextPc;
                        lastPc  <= fetchPc;
                    end
                end
                default: state <= fetchTypes::Run;  // recover lasts one cycle.
            endcase
        end
    end

    // a stall only answers a line requested in run.
    stallOnlyInRun: assert property (@(posedge clk) disable iff (!rstN)
        stall |-> state == fetchTypes::Run);

endmodule

`default_nettype wire

// ==== lineMemory.sv ====
//----------------------------------------
// line memory in place of the i-cache read stage.
// loaded one word at a time, no tags, no refill.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lineMemory (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            reqValid,
    input  wire rvTypes::vaddr_t reqPc,
    input  wire logic            redirect,
    input  wire logic            memWrite,
    input  wire rvTypes::vaddr_t memWordAddr,
    input  wire rvTypes::word_t  memWord,
    lineReadIf.source            lineRead
);

    rvTypes::word_t [fetchTypes::WORDS_PER_LINE-1:0] mem [fetchTypes::MEM_LINES];

    fetchTypes::lineIndex_t readIndex;
    fetchTypes::lineIndex_t writeIndex;
    logic outOfRange;

    always_comb begin
        readIndex  = reqPc[fetchTypes::LINE_OFFSET_BITS +: fetchTypes::LINE_INDEX_BITS];
        writeIndex = memWordAddr[fetchTypes::LINE_OFFSET_BITS +: fetchTypes::LINE_INDEX_BITS];
        outOfRange = reqPc >= fetchTypes::MEM_BYTES;
    end

    // word writes past the end are dropped.
    always_ff @(posedge clk) begin
        if (memWrite && memWordAddr < fetchTypes::MEM_BYTES) begin
            mem[writeIndex][memWordAddr[fetchTypes::LINE_OFFSET_BITS-1:2]] <= memWord;
        end
    end

    // redirect kills the request issued in the same cycle.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lineRead.valid <= 1'b0;
        end else begin
            lineRead.valid <= reqValid && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        lineRead.pc    <= reqPc;
        lineRead.fault <= outOfRange;
        lineRead.line  <= outOfRange ? '0 : mem[readIndex];  // zeros on a fault.
    end

endmodule

`default_nettype wire

// ==== insnTraverse.sv ====
//----------------------------------------
// splits the addressed word into parcels.
// needs two free entries even for a single write.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module insnTraverse (
    lineReadIf.sink                 lineRead,
    insnBufferIf.writer             buffer,
    input  wire logic               intValid,
    input  wire rvTypes::intCode_t  intCode,
    output logic                    stall
);

    rvTypes::word_t [fetchTypes::WORDS_PER_LINE-1:0] words;
    rvTypes::word_t word;
    logic upperOnly;   // pc points at the high parcel.
    logic room;

    always_comb begin
        words     = lineRead.line;
        word      = words[lineRead.pc[fetchTypes::LINE_OFFSET_BITS-1:2]];
        upperOnly = lineRead.pc[1];
        room      = buffer.writableCount >= fetchTypes::bufCount_t'(2);
    end

    assign stall = lineRead.valid && !room;   // controller rewinds to this pc.

    always_comb begin
        buffer.writeHigh = lineRead.valid && room;
        buffer.writeLow  = lineRead.valid && room && !upperOnly;
        buffer.pcLow     = lineRead.pc;
        buffer.pcHigh    = upperOnly ? lineRead.pc
                                     : lineRead.pc + rvTypes::vaddr_t'(rvTypes::HALF_BYTES);
        buffer.halfLow   = word[15:0];
        buffer.halfHigh  = word[31:16];
        buffer.fault     = lineRead.fault;   // same tags on both parcels.
        buffer.intValid  = intValid;
        buffer.intCode   = intCode;
    end

    // parcels sit on even addresses only.
    always_comb begin
        if (lineRead.valid) begin
            evenPc: assert (!lineRead.pc[0]);
        end
    end

endmodule

`default_nettype wire

// ==== insnBuffer.sv ====
//----------------------------------------
// circular halfword buffer, two writes and one pop per cycle.
// flush drops the writes of the same cycle.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module insnBuffer (
    input  wire logic               clk,
    input  wire logic               rstN,
    insnBufferIf.buffer             buffer,
    input  wire logic               flush,
    input  wire logic               pop,
    output logic                    outValid,
    output rvTypes::vaddr_t         outPc,
    output rvTypes::half_t          outHalf,
    output logic                    outFault,
    output logic                    outIntValid,
    output rvTypes::intCode_t       outIntCode
);

    rvTypes::vaddr_t   pcs      [fetchTypes::BUFFER_DEPTH];
    rvTypes::half_t    halves   [fetchTypes::BUFFER_DEPTH];
    logic              faults   [fetchTypes::BUFFER_DEPTH];
    logic              intFlags [fetchTypes::BUFFER_DEPTH];
    rvTypes::intCode_t intCodes [fetchTypes::BUFFER_DEPTH];

    fetchTypes::bufPtr_t   head;
    fetchTypes::bufPtr_t   tail;
    fetchTypes::bufPtr_t   highSlot;   // slot of the high parcel.
    fetchTypes::bufCount_t count;
    fetchTypes::bufCount_t pushCount;
    logic popNow;

    always_comb begin
        pushCount = fetchTypes::bufCount_t'(buffer.writeLow)
                  + fetchTypes::bufCount_t'(buffer.writeHigh);
        highSlot  = tail + fetchTypes::bufPtr_t'(buffer.writeLow);  // after the low one.
        popNow    = pop && outValid;
    end

    assign buffer.writableCount = fetchTypes::bufCount_t'(fetchTypes::BUFFER_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (!flush && buffer.writeLow) begin
            pcs[tail]      <= buffer.pcLow;
            halves[tail]   <= buffer.halfLow;
            faults[tail]   <= buffer.fault;
            intFlags[tail] <= buffer.intValid;
            intCodes[tail] <= buffer.intCode;
        end
        if (!flush && buffer.writeHigh) begin
            pcs[highSlot]      <= buffer.pcHigh;
            halves[highSlot]   <= buffer.halfHigh;
            faults[highSlot]   <= buffer.fault;
            intFlags[highSlot] <= buffer.intValid;
            intCodes[highSlot] <= buffer.intCode;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + fetchTypes::bufPtr_t'(pushCount);
            head  <= popNow ? head + fetchTypes::bufPtr_t'(1) : head;
            count <= count + pushCount - fetchTypes::bufCount_t'(popNow);
        end
    end

    // head entry, readable from the cycle after its write.
    always_comb begin
        outValid    = count != '0;
        outPc       = pcs[head];
        outHalf     = halves[head];
        outFault    = faults[head];
        outIntValid = intFlags[head];
        outIntCode  = intCodes[head];
    end

    // the writer must respect the free count it was given.
    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        !flush |-> pushCount <= buffer.writableCount);

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        pop |-> outValid);

endmodule

`default_nettype wire

// ==== timerInterrupt.sv ====
//----------------------------------------
// machine timer, the counter never stops.
// the compare register resets to all ones.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module timerInterrupt (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   timerEnable,
    input  wire logic                   compareWrite,
    input  wire fetchTypes::timeCount_t compareValue,
    output logic                        intValid,
    output rvTypes::intCode_t           intCode
);

    fetchTypes::timeCount_t count;
    fetchTypes::timeCount_t compare;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count   <= '0;
            compare <= '1;   // far off until written.
        end else begin
            count <= count + fetchTypes::timeCount_t'(1);
            if (compareWrite) begin
                compare <= compareValue;
            end
        end
    end

    // level, held until compare moves or the timer is disabled.
    assign intValid = timerEnable && (count >= compare);
    assign intCode  = rvTypes::TIMER_INT_CODE;

endmodule

`default_nettype wire

// ==== fetchTop.sv ====
//----------------------------------------
// fetch front end top, wiring only.
// pop must stay low while outValid is low.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetchTop (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   start,
    input  wire rvTypes::vaddr_t        startPc,
    input  wire logic                   redirect,
    input  wire rvTypes::vaddr_t        redirectPc,
    input  wire logic                   memWrite,
    input  wire rvTypes::vaddr_t        memWordAddr,
    input  wire rvTypes::word_t         memWord,
    input  wire logic                   timerEnable,
    input  wire logic                   compareWrite,
    input  wire fetchTypes::timeCount_t compareValue,
    input  wire logic                   pop,
    output logic                        outValid,
    output rvTypes::vaddr_t             outPc,
    output rvTypes::half_t              outHalf,
    output logic                        outFault,
    output logic                        outIntValid,
    output rvTypes::intCode_t           outIntCode
);

    logic              reqValid;
    rvTypes::vaddr_t   reqPc;
    logic              stall;
    logic              intValid;
    rvTypes::intCode_t intCode;

    lineReadIf   lineRead ();
    insnBufferIf bufferBus ();

    fetchController u_fetchController (
        .clk, .rstN, .start, .startPc, .redirect, .redirectPc,
        .stall, .reqValid, .reqPc
    );

    lineMemory u_lineMemory (
        .clk, .rstN, .reqValid, .reqPc, .redirect,
        .memWrite, .memWordAddr, .memWord, .lineRead(lineRead.source)
    );

    insnTraverse u_insnTraverse (
        .lineRead(lineRead.sink), .buffer(bufferBus.writer),
        .intValid, .intCode, .stall
    );

    // redirect doubles as the buffer flush.
    insnBuffer u_insnBuffer (
        .clk, .rstN, .buffer(bufferBus.buffer), .flush(redirect), .pop,
        .outValid, .outPc, .outHalf, .outFault, .outIntValid, .outIntCode
    );

    timerInterrupt u_timerInterrupt (
        .clk, .rstN, .timerEnable, .compareWrite, .compareValue,
        .intValid, .intCode
    );

endmodule

`default_nettype wire

// ==== tbFetch.sv ====
//----------------------------------------
// testbench for the fetch front end, run from the project root.
// commands and expected counts come from fetchStimulus.mem.
// pop only follows a cycle without pop, so the head is always there.
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbFetch;

    localparam int STIM_DEPTH       = 32;
    localparam int MEM_WORDS        = 64;      // 256 bytes of line memory.
    localparam int CYCLES_PER_ENTRY = 64;
    localparam logic [31:0] MEM_BYTES  = 32'd256;
    localparam logic [3:0]  TIMER_CODE = 4'd7; // machine timer cause.

    logic clk = 1'b0;
    logic rstN;
    logic start;
    rvTypes::vaddr_t startPc;
    logic redirect;
    rvTypes::vaddr_t redirectPc;
    logic memWrite;
    rvTypes::vaddr_t memWordAddr;
    rvTypes::word_t memWord;
    logic timerEnable;
    logic compareWrite;
    fetchTypes::timeCount_t compareValue;
    logic pop;
    logic outValid;
    rvTypes::vaddr_t outPc;
    rvTypes::half_t outHalf;
    logic outFault;
    logic outIntValid;
    rvTypes::intCode_t outIntCode;

    logic [71:0] stim [STIM_DEPTH];          // {cmd, a, b} per record.
    rvTypes::word_t model [MEM_WORDS];       // copy of the line memory.
    logic timerOn;                           // entries expected with intValid.
    logic [31:0] gapMask;                    // pop skipped unless random bits clear.
    integer seed = 32'hc2db9dd7;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;
    int timeoutLimit;

    fetchTop u_fetchTop (
        .clk, .rstN, .start, .startPc, .redirect, .redirectPc,
        .memWrite, .memWordAddr, .memWord, .timerEnable, .compareWrite, .compareValue,
        .pop, .outValid, .outPc, .outHalf, .outFault, .outIntValid, .outIntCode
    );

    always #20 clk = ~clk;   // 40 ns period.

    // hard stop when entries never show up.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeoutLimit) begin
            $display("timeout after %0d cycles, expected entries never arrived", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic rvTypes::word_t fillWord(input rvTypes::vaddr_t addr,
                                                input logic [31:0] key);
        return (addr * 32'h9e3779b1) ^ key;   // every address bit matters.
    endfunction

    // parcel at pc, low half first, zero past the memory.
    function automatic rvTypes::half_t expectedHalf(input rvTypes::vaddr_t pc);
        rvTypes::word_t w;
        if (pc >= MEM_BYTES) return '0;
        w = model[pc[7:2]];
        return pc[1] ? w[31:16] : w[15:0];
    endfunction

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkEntry(input rvTypes::vaddr_t pc);
        logic fault;
        fault = pc >= MEM_BYTES;
        checkField("outPc", pc, outPc);
        checkField("outHalf", 32'(expectedHalf(pc)), 32'(outHalf));
        checkField("outFault", 32'(fault), 32'(outFault));
        checkField("outIntValid", 32'(timerOn), 32'(outIntValid));
        if (timerOn) checkField("outIntCode", 32'(TIMER_CODE), 32'(outIntCode));
    endtask

    task automatic resetDut();
        rstN     <= 1'b0;
        start    <= 1'b0;
        redirect <= 1'b0;
        pop      <= 1'b0;
        memWrite <= 1'b0;
        compareWrite <= 1'b0;
        timerOn  = 1'b0;   // compare goes back to all ones.
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic writeWord(input rvTypes::vaddr_t addr, input rvTypes::word_t data);
        @(posedge clk);
        memWrite    <= 1'b1;
        memWordAddr <= addr;
        memWord     <= data;
        if (addr < MEM_BYTES) model[addr[7:2]] = data;
        @(posedge clk);
        memWrite <= 1'b0;
    endtask

    task automatic setTimer(input logic enable, input logic [31:0] compare);
        @(posedge clk);
        timerEnable  <= enable;
        compareWrite <= 1'b1;
        compareValue <= compare;
        @(posedge clk);
        compareWrite <= 1'b0;
        timerOn = enable && (compare == 32'd0);   // count is always past zero.
    endtask

    // start or redirect, then pop and check count entries.
    task automatic runTest(input logic useStart, input rvTypes::vaddr_t pc, input int count);
        rvTypes::vaddr_t expPc;
        int got;
        int errorsBefore;
        logic nextPop;
        string kind;
        expPc = pc;
        got = 0;
        errorsBefore = errors;
        if (useStart) kind = "start";
        else kind = "redirect";
        @(posedge clk);
        pop <= 1'b0;
        if (useStart) begin
            start   <= 1'b1;
            startPc <= pc;
        end else begin
            redirect   <= 1'b1;   // also flushes the old stream.
            redirectPc <= pc;
        end
        @(posedge clk);
        start    <= 1'b0;
        redirect <= 1'b0;
        while (got < count) begin
            @(negedge clk);   // outputs settled mid-cycle.
            if (pop && outValid) begin
                checkEntry(expPc);
                expPc = expPc + 32'd2;
                got++;
            end
            nextPop = outValid && !pop && (got < count)
                      && (($random(seed) & gapMask) == 32'd0);
            @(posedge clk);
            pop <= nextPop;
        end
        tests++;
        $display("test %0d %s at %h, %0d entries, %0d errors",
                 tests, kind, pc, count, errors - errorsBefore);
    endtask

    initial begin
        int idx;
        logic [7:0] cmd;
        logic [31:0] a;
        logic [31:0] b;
        rstN = 1'b0;
        start = 1'b0;
        startPc = '0;
        redirect = 1'b0;
        redirectPc = '0;
        memWrite = 1'b0;
        memWordAddr = '0;
        memWord = '0;
        timerEnable = 1'b0;
        compareWrite = 1'b0;
        compareValue = '0;
        pop = 1'b0;
        gapMask = '0;
        for (int i = 0; i < STIM_DEPTH; i++) stim[i] = '0;
        $readmemh("fetchStimulus.mem", stim);
        timeoutLimit = 0;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            if (stim[i][71:64] == 8'h05 || stim[i][71:64] == 8'h06)
                timeoutLimit = timeoutLimit + CYCLES_PER_ENTRY * int'(stim[i][31:0]);
        end
        resetDut();
        idx = 0;
        while (idx < STIM_DEPTH && stim[idx][71:64] != 8'h00) begin
            cmd = stim[idx][71:64];
            a   = stim[idx][63:32];
            b   = stim[idx][31:0];
            case (cmd)
                8'h01: for (int w = 0; w < MEM_WORDS; w++)
                    writeWord(rvTypes::vaddr_t'(w * 4), fillWord(rvTypes::vaddr_t'(w * 4), a));
                8'h02: writeWord(a, b);
                8'h03: setTimer(a[0], b);
                8'h04: gapMask = a;
                8'h05: runTest(1'b1, a, int'(b));
                8'h06: runTest(1'b0, a, int'(b));
                8'h07: resetDut();
                default: begin
                    $display("record %0d holds unknown command %h", idx, cmd);
                    errors++;
                end
            endcase
            idx++;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetchStimulus.mem ====
// each line holds a command byte, operand a and operand b, all hex.
// 01 fill key, 02 write addr word, 03 timer enable compare, 04 pop gap mask,
// 05 start pc entries, 06 redirect pc entries, 07 reset, 00 end of list.
01_5a5aa5a5_00000000 // fill the whole memory.
02_00000010_12345678 // marker word in the first stream.
02_000000fc_deadbeef // last word before the end.
03_00000000_ffffffff // timer off.
04_00000000_00000000 // pop at full rate.
05_00000000_00000018 // aligned start.
07_00000000_00000000
05_00000006_0000000c // start on an upper half.
04_00000003_00000000 // random pop gaps.
06_00000000_00000018 // mid-stream redirect, same stream as the first.
04_00000000_00000000
06_000000f0_00000014 // runs past the end of memory.
03_00000001_00000000 // timer on, compare zero.
06_00000040_00000010
03_00000000_ffffffff // timer off again.
06_00000082_00000008 // redirect onto an upper half.
00_00000000_00000000

// ==== filelist.f ====
rvTypes.sv
fetchTypes.sv
fetchIfs.sv
fetchController.sv
lineMemory.sv
insnTraverse.sv
insnBuffer.sv
timerInterrupt.sv
fetchTop.sv
tbFetch.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbFetch
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail when the log reports failure"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
